/* source/mips_alu_pkg.sv */
// shared word, opcode and select types plus opcode encodings for the execute unit.
package mips_alu_pkg;

    // ********************
    // widths
    // ********************
    localparam int WORD_W   = 32;
    localparam int OP_W     = 6;
    localparam int SHAMT_W  = 5;
    localparam int SHSEL_W  = 2;
    localparam int LGSEL_W  = 3;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [OP_W-1:0]    alu_op_t;
    typedef logic [SHAMT_W-1:0] shamt_t;
    typedef logic [SHSEL_W-1:0] shift_sel_t;
    typedef logic [LGSEL_W-1:0] logic_sel_t;

    // ********************
    // opcodes
    // ********************
    // bit 0 subtract, bits 2..1 shift, bits 5..3 logical.
    localparam alu_op_t ADD_OP  = 6'b000000;
    localparam alu_op_t SUB_OP  = 6'b000001;
    localparam alu_op_t SHL_OP  = 6'b000010;
    localparam alu_op_t LSR_OP  = 6'b000100;
    localparam alu_op_t ASR_OP  = 6'b000110;
    localparam alu_op_t OR_OP   = 6'b001000;
    localparam alu_op_t AND_OP  = 6'b010000;
    localparam alu_op_t XOR_OP  = 6'b011000;
    localparam alu_op_t NOR_OP  = 6'b100000;
    localparam alu_op_t SLT_OP  = 6'b101001;
    localparam alu_op_t SLTU_OP = 6'b110001;

    // shifter selects, 00 passes through.
    localparam shift_sel_t SHIFT_SHL = 2'b01;
    localparam shift_sel_t SHIFT_LSR = 2'b10;
    localparam shift_sel_t SHIFT_ASR = 2'b11;

    // logical selects, others give zero.
    localparam logic_sel_t LOGIC_OR  = 3'b001;
    localparam logic_sel_t LOGIC_AND = 3'b010;
    localparam logic_sel_t LOGIC_XOR = 3'b011;
    localparam logic_sel_t LOGIC_NOR = 3'b100;

endpackage

/* source/alu_adder.sv */
// 32-bit adder with carry in and out and signed overflow, used for add, sub and compares.
`timescale 1ns/1ps

module alu_adder (
    input  mips_alu_pkg::word_t op1_i,
    input  mips_alu_pkg::word_t op2_i,
    input  logic                cin_i,
    output mips_alu_pkg::word_t sum_o,
    output logic                carry_o,
    output logic                ovf_o
);

    logic same_sign;

    // 33-bit sum, top bit is the carry out.
    assign {carry_o, sum_o} = op1_i + op2_i + cin_i;

    assign same_sign = (op1_i[31] == op2_i[31]);

    // operands agree in sign, sum does not.
    assign ovf_o = same_sign & (sum_o[31] != op1_i[31]);

endmodule

/* source/alu_shifter.sv */
// five-stage barrel shifter for left, logical right and arithmetic right shifts.
`timescale 1ns/1ps

module alu_shifter (
    input  mips_alu_pkg::word_t      op1_i,
    input  mips_alu_pkg::shamt_t     shamt_i,
    input  mips_alu_pkg::shift_sel_t shift_sel_i,
    output mips_alu_pkg::word_t      res_o
);

    import mips_alu_pkg::*;

    word_t stage [6];
    logic  shift_en;
    logic  fill;

    assign shift_en = (shift_sel_i == SHIFT_SHL) || (shift_sel_i == SHIFT_LSR) ||
                      (shift_sel_i == SHIFT_ASR);
    assign fill     = (shift_sel_i == SHIFT_ASR) & op1_i[31];  // sign fill for asr.

    assign stage[0] = op1_i;

    // ********************
    // stage g shifts by 2**g
    // ********************
    genvar g;
    generate
        for (g = 0; g < 5; g++) begin : g_stage
            always_comb begin
                if (!shift_en || !shamt_i[g]) begin
                    stage[g+1] = stage[g];
                end else if (shift_sel_i == SHIFT_SHL) begin
                    stage[g+1] = stage[g] << (2 ** g);
                end else begin
                    stage[g+1] = (stage[g] >> (2 ** g)) |
                                 ({32{fill}} & ~(32'hFFFF_FFFF >> (2 ** g)));
                end
            end
        end
    endgenerate

    assign res_o = stage[5];

endmodule

/* source/alu_logical.sv */
// bitwise logic unit, OR, AND, XOR or NOR chosen by the opcode's top three bits.
`timescale 1ns/1ps

module alu_logical (
    input  mips_alu_pkg::word_t      op1_i,
    input  mips_alu_pkg::word_t      op2_i,
    input  mips_alu_pkg::logic_sel_t logic_sel_i,
    output mips_alu_pkg::word_t      res_o
);

    import mips_alu_pkg::*;

    always_comb begin
        case (logic_sel_i)
            LOGIC_OR: begin
                res_o = op1_i | op2_i;
            end
            LOGIC_AND: begin
                res_o = op1_i & op2_i;
            end
            LOGIC_XOR: begin
                res_o = op1_i ^ op2_i;
            end
            LOGIC_NOR: begin
                res_o = ~(op1_i | op2_i);
            end
            default: begin
                res_o = '0;  // unused selects.
            end
        endcase
    end

endmodule

/* source/alu.sv */
// combinational ALU, conditions operand b, picks the unit result and derives the flags.
`timescale 1ns/1ps

module alu (
    input  mips_alu_pkg::word_t   opr_a_alu_i,
    input  mips_alu_pkg::word_t   opr_b_alu_i,
    input  mips_alu_pkg::alu_op_t op_alu_i,
    output mips_alu_pkg::word_t   res_alu_o,
    output logic                  z_alu_o,
    output logic                  n_alu_o
);

    import mips_alu_pkg::*;

    word_t  opr_b_cond;
    logic   cin_alu;
    word_t  adder_out;
    logic   carry_out;
    logic   v_alu;
    word_t  shifter_out;
    word_t  logical_out;
    logic   n_alu;
    logic   ltu_alu;
    word_t  res_alu;

    // ********************
    // operand conditioning
    // ********************
    assign opr_b_cond = op_alu_i[0] ? ~opr_b_alu_i : opr_b_alu_i;  // a + ~b + 1 on sub.
    assign cin_alu    = op_alu_i[0];

    // ********************
    // units
    // ********************
    alu_adder adder_inst (
        .op1_i   (opr_a_alu_i),
        .op2_i   (opr_b_cond),
        .cin_i   (cin_alu),
        .sum_o   (adder_out),
        .carry_o (carry_out),
        .ovf_o   (v_alu)
    );

    alu_shifter shifter_inst (
        .op1_i       (opr_a_alu_i),
        .shamt_i     (opr_b_alu_i[4:0]),
        .shift_sel_i (op_alu_i[2:1]),
        .res_o       (shifter_out)
    );

    alu_logical logical_inst (
        .op1_i       (opr_a_alu_i),
        .op2_i       (opr_b_alu_i),
        .logic_sel_i (op_alu_i[5:3]),
        .res_o       (logical_out)
    );

    // true sign of the difference, corrected on overflow.
    assign n_alu   = v_alu ? opr_a_alu_i[31] : adder_out[31];
    assign ltu_alu = ~carry_out;  // no carry out means a < b unsigned.

    // ********************
    // result select
    // ********************
    always_comb begin
        case (op_alu_i)
            ADD_OP, SUB_OP: begin
                res_alu = adder_out;
            end
            SHL_OP, LSR_OP, ASR_OP: begin
                res_alu = shifter_out;
            end
            OR_OP, AND_OP, XOR_OP, NOR_OP: begin
                res_alu = logical_out;
            end
            SLT_OP: begin
                res_alu = {31'b0, n_alu};
            end
            SLTU_OP: begin
                res_alu = {31'b0, ltu_alu};
            end
            default: begin
                res_alu = '0;
            end
        endcase
    end

    assign res_alu_o = res_alu;
    assign z_alu_o   = (res_alu == '0);
    assign n_alu_o   = n_alu;

endmodule

/* source/alu_exec.sv */
// execute stage top, one-cycle registered ALU issued by a valid strobe every cycle.
`timescale 1ns/1ps

module alu_exec (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  mips_alu_pkg::alu_op_t op_i,
    input  mips_alu_pkg::word_t   opr_a_i,
    input  mips_alu_pkg::word_t   opr_b_i,
    output logic                  valid_o,
    output mips_alu_pkg::word_t   res_o,
    output logic                  z_o,
    output logic                  n_o
);

    import mips_alu_pkg::*;

    word_t res_alu;
    logic  z_alu;
    logic  n_alu;

    // ********************
    // combinational ALU
    // ********************
    alu alu_inst (
        .opr_a_alu_i (opr_a_i),
        .opr_b_alu_i (opr_b_i),
        .op_alu_i    (op_i),
        .res_alu_o   (res_alu),
        .z_alu_o     (z_alu),
        .n_alu_o     (n_alu)
    );

    // ********************
    // output register
    // ********************
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;  // one strobe per issue.
        end
    end

    // data holds its last value between issues.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_o <= '0;
            z_o   <= 1'b0;
            n_o   <= 1'b0;
        end else if (valid_i) begin
            res_o <= res_alu;
            z_o   <= z_alu;
            n_o   <= n_alu;
        end
    end

endmodule

/* tb/alu_checker.sv */
// checker that queues expected alu results per issue and compares them one cycle later.
`timescale 1ns/1ps

module alu_checker (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  mips_alu_pkg::alu_op_t op_i,
    input  mips_alu_pkg::word_t   opr_a_i,
    input  mips_alu_pkg::word_t   opr_b_i,
    input  logic                  dut_valid_i,
    input  mips_alu_pkg::word_t   dut_res_i,
    input  logic                  dut_z_i,
    input  logic                  dut_n_i,
    input  mips_alu_pkg::word_t   exp_res_i,
    input  logic                  exp_z_i,
    input  logic                  exp_n_i,
    output int                    checked_o,
    output int                    errors_o
);

    import mips_alu_pkg::*;

    alu_op_t op_q [$];
    word_t   a_q [$];
    word_t   b_q [$];
    word_t   res_q [$];
    logic    z_q [$];
    logic    n_q [$];
    logic    valid_d = 1'b0;  // valid_i seen one cycle back.
    word_t   last_res = '0;  // outputs hold this in idle cycles.
    logic    last_z = 1'b0;
    logic    last_n = 1'b0;
    int      checked_cnt = 0;
    int      error_cnt = 0;

    assign checked_o = checked_cnt;
    assign errors_o  = error_cnt;

    // sample on the falling edge where inputs and outputs have settled.
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            valid_d  = 1'b0;
            last_res = '0;
            last_z   = 1'b0;
            last_n   = 1'b0;
            if (dut_valid_i !== 1'b0 || dut_res_i !== '0 || dut_z_i !== 1'b0 ||
                dut_n_i !== 1'b0) begin
                $display("error at %0t: outputs not clear in reset, valid %b res %h z %b n %b",
                         $time, dut_valid_i, dut_res_i, dut_z_i, dut_n_i);
                error_cnt++;
            end
        end else begin
            if (dut_valid_i !== valid_d) begin
                $display("error at %0t: valid_o is %b, expected %b one cycle after valid_i",
                         $time, dut_valid_i, valid_d);
                error_cnt++;
            end
            if (dut_valid_i === 1'b0 && (dut_res_i !== last_res || dut_z_i !== last_z ||
                dut_n_i !== last_n)) begin
                $display("error at %0t: idle outputs res %h z %b n %b, expected %h %b %b",
                         $time, dut_res_i, dut_z_i, dut_n_i, last_res, last_z, last_n);
                error_cnt++;
            end
            if (dut_valid_i === 1'b1) begin
                if (op_q.size() == 0) begin
                    $display("a result arrived at %0t with no operation outstanding", $time);
                    error_cnt++;
                end else begin
                    if (dut_res_i !== res_q[0] || dut_z_i !== z_q[0] || dut_n_i !== n_q[0]) begin
                        $display("error at %0t: op %h a %h b %h, expected res %h z %b n %b, %s",
                                 $time, op_q[0], a_q[0], b_q[0], res_q[0], z_q[0], n_q[0],
                                 $sformatf("got res %h z %b n %b", dut_res_i, dut_z_i, dut_n_i));
                        error_cnt++;
                    end
                    last_res = res_q[0];
                    last_z   = z_q[0];
                    last_n   = n_q[0];
                    void'(op_q.pop_front());
                    void'(a_q.pop_front());
                    void'(b_q.pop_front());
                    void'(res_q.pop_front());
                    void'(z_q.pop_front());
                    void'(n_q.pop_front());
                    checked_cnt++;
                end
            end
            if (valid_i === 1'b1) begin
                op_q.push_back(op_i);
                a_q.push_back(opr_a_i);
                b_q.push_back(opr_b_i);
                res_q.push_back(exp_res_i);
                z_q.push_back(exp_z_i);
                n_q.push_back(exp_n_i);
            end
            valid_d = valid_i;
        end
    end

endmodule

/* tb/tb_alu_exec.sv */
// testbench top that plays the vector file through the execute unit with idle gaps.
`timescale 1ns/1ps

module tb_alu_exec;

    import mips_alu_pkg::*;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 3;
    localparam int    BURST_LEN    = 10;  // issued back-to-back.
    localparam int    MAX_GAP      = 3;
    localparam int    DRAIN_LIMIT  = 50;
    localparam int    SEED         = 70888;
    localparam string VEC_FILE     = "tb/alu_vectors.txt";

    logic    clk_i;
    logic    rst_n_i;
    logic    valid_i;
    alu_op_t op_i;
    word_t   opr_a_i;
    word_t   opr_b_i;
    logic    valid_o;
    word_t   res_o;
    logic    z_o;
    logic    n_o;
    word_t   exp_res;
    logic    exp_z;
    logic    exp_n;
    int      checked;
    int      checker_errors;
    int      tb_errors;
    int      issued;

    alu_op_t vec_op [$];
    word_t   vec_a [$];
    word_t   vec_b [$];
    word_t   vec_res [$];
    logic    vec_z [$];
    logic    vec_n [$];

    alu_exec alu_exec_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .op_i    (op_i),
        .opr_a_i (opr_a_i),
        .opr_b_i (opr_b_i),
        .valid_o (valid_o),
        .res_o   (res_o),
        .z_o     (z_o),
        .n_o     (n_o)
    );

    alu_checker checker_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .opr_a_i     (opr_a_i),
        .opr_b_i     (opr_b_i),
        .dut_valid_i (valid_o),
        .dut_res_i   (res_o),
        .dut_z_i     (z_o),
        .dut_n_i     (n_o),
        .exp_res_i   (exp_res),
        .exp_z_i     (exp_z),
        .exp_n_i     (exp_n),
        .checked_o   (checked),
        .errors_o    (checker_errors)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ********************
    // vector file
    // ********************
    task automatic read_vectors();
        int          fd;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_res;
        logic [31:0] f_z;
        logic [31:0] f_n;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VEC_FILE);
            tb_errors++;
        end else begin
            // comment lines fail the scan and drop out.
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %h %h %h %h %h",
                            f_op, f_a, f_b, f_res, f_z, f_n) == 6) begin
                    vec_op.push_back(f_op[5:0]);
                    vec_a.push_back(f_a);
                    vec_b.push_back(f_b);
                    vec_res.push_back(f_res);
                    vec_z.push_back(f_z[0]);
                    vec_n.push_back(f_n[0]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic issue_op(input int idx);
        valid_i <= 1'b1;
        op_i    <= vec_op[idx];
        opr_a_i <= vec_a[idx];
        opr_b_i <= vec_b[idx];
        exp_res <= vec_res[idx];
        exp_z   <= vec_z[idx];
        exp_n   <= vec_n[idx];
    endtask

    // ********************
    // stimulus
    // ********************
    initial begin
        int unsigned gap;
        int          waited;
        rst_n_i   = 1'b0;
        valid_i   = 1'b0;
        op_i      = '0;
        opr_a_i   = '0;
        opr_b_i   = '0;
        exp_res   = '0;
        exp_z     = 1'b0;
        exp_n     = 1'b0;
        tb_errors = 0;
        issued    = 0;
        void'($urandom(SEED));
        read_vectors();
        if (vec_op.size() == 0) begin
            $display("no vectors were read, nothing to test");
            tb_errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);  // one idle cycle after reset.
        for (int i = 0; i < vec_op.size(); i++) begin
            @(posedge clk_i);
            issue_op(i);
            issued++;
            if (i >= BURST_LEN) begin
                gap = $urandom % (MAX_GAP + 1);
                repeat (gap) begin
                    @(posedge clk_i);
                    valid_i <= 1'b0;
                end
            end
        end
        @(posedge clk_i);
        valid_i <= 1'b0;
        waited = 0;
        while (checked != issued && waited < DRAIN_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (checked != issued) begin
            $display("timed out, only %0d of %0d results arrived", checked, issued);
            tb_errors++;
        end
        repeat (4) @(posedge clk_i);  // valid_o must stay low here.
        $display("errors: checker %0d, testbench %0d, results checked %0d of %0d",
                 checker_errors, tb_errors, checked, issued);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/mips_alu_pkg.sv
source/alu_adder.sv
source/alu_shifter.sv
source/alu_logical.sv
source/alu.sv
source/alu_exec.sv
tb/alu_checker.sv
tb/tb_alu_exec.sv

/* run.sh */
#!/bin/sh
# builds the execute unit testbench with verilator, runs it and greps the log for the verdict.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_alu_exec

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f verilog.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* tb/alu_vectors.txt */
// columns: opcode, operand a, operand b, expected result, expected zero, expected negative
// all fields hex, one operation per line
00 00000005 00000003 00000008 0 0
00 ffffffff 00000001 00000000 1 0
01 00000007 00000007 00000000 1 0
01 00000003 00000005 fffffffe 0 1
01 80000000 00000001 7fffffff 0 1
00 7fffffff 00000001 80000000 0 0
00 80000000 80000000 00000000 1 1
02 00000001 0000001f 80000000 0 0
02 0000000f 00000021 0000001e 0 0
02 80000001 00000001 00000002 0 1
04 80000000 0000001f 00000001 0 1
04 f0000000 00000004 0f000000 0 1
06 80000000 0000001f ffffffff 0 1
06 f0000000 00000024 ff000000 0 1
06 00000001 00000041 00000000 1 0
08 00000000 00000000 00000000 1 0
08 aaaaaaaa 55555555 ffffffff 0 1
10 ffffffff aaaaaaaa aaaaaaaa 0 1
10 aaaaaaaa 55555555 00000000 1 1
18 ffffffff ffffffff 00000000 1 1
20 00000000 00000000 ffffffff 0 0
20 aaaaaaaa 55555555 00000000 1 1
29 ffffffff 00000001 00000001 0 1
31 ffffffff 00000001 00000000 1 1
29 00000001 ffffffff 00000000 1 0
31 00000001 ffffffff 00000001 0 0
29 80000000 7fffffff 00000001 0 1
31 80000000 7fffffff 00000000 1 1
31 00000003 00000004 00000001 0 1
31 00000005 00000005 00000000 1 0
3f 00000003 00000005 00000000 1 1
0a 12345678 11111111 00000000 1 0
